/* src/icache_config.svh */
`ifndef ICACHE_CONFIG_SVH
`define ICACHE_CONFIG_SVH

// Address split, tag | index | word offset | byte
`define ICACHE_ADDR_W      32
`define ICACHE_INDEX_W     8
`define ICACHE_OFFSET_W    2
`define ICACHE_TAG_W       20

// Line geometry
`define ICACHE_LINE_WORDS  4

// Fixed AR channel fields
`define ICACHE_AR_LEN      8'd3     // Four beats per line
`define ICACHE_AR_SIZE     3'b010   // 4-byte beats
`define ICACHE_AR_BURST    2'b01    // INCR
`define ICACHE_AR_CACHE    4'b1111
`define ICACHE_AR_ID       1'b0
`define ICACHE_AR_LOCK     1'b0     // Normal access

`endif

/* src/icache_pkg.sv */
`include "icache_config.svh"

package icache_pkg;

    typedef logic [`ICACHE_ADDR_W-1:0] word_t;  // pc, instruction, AXI data

    typedef logic [`ICACHE_TAG_W-1:0]   tag_t;    // pc[31:12]
    typedef logic [`ICACHE_INDEX_W-1:0] index_t;  // pc[11:4]

    // Word 0 sits in the low bits
    typedef logic [`ICACHE_LINE_WORDS*`ICACHE_ADDR_W-1:0] line_t;

    // Carried alongside each fetch
    typedef struct packed {
        word_t       pc;
        logic        branch_taken;
        logic [30:0] branch_target;
    } fetch_info_t;

    // Output stage payload
    typedef struct packed {
        fetch_info_t info;
        word_t       inst;
    } fetch_out_t;

endpackage

/* src/icache_store.sv */
`timescale 1ns/1ps
`include "icache_config.svh"

module icache_store (
    input  logic               m_axi_aclk,
    input  logic               m_axi_aresetn,

    // Read port, data one cycle after the enabled edge
    input  logic               ren_i,
    input  icache_pkg::index_t raddr_i,

    // Write port, refill of a whole line
    input  logic               wen_i,
    input  icache_pkg::index_t waddr_i,
    input  icache_pkg::tag_t   wtag_i,
    input  icache_pkg::line_t  wline_i,

    output icache_pkg::tag_t   rtag_o,
    output logic               rvalid_o,
    output icache_pkg::line_t  rline_o
);
    import icache_pkg::*;

    localparam int DEPTH = 1 << `ICACHE_INDEX_W;

    tag_t             tag_mem  [DEPTH];
    line_t            line_mem [DEPTH];
    logic [DEPTH-1:0] valid_q;  // One bit per line, cleared on reset

    // Tag and line arrays
    always_ff @(posedge m_axi_aclk) begin
        if (wen_i) begin
            tag_mem[waddr_i]  <= wtag_i;
            line_mem[waddr_i] <= wline_i;
        end
    end

    always_ff @(posedge m_axi_aclk) begin
        if (ren_i) begin
            rtag_o  <= tag_mem[raddr_i];
            rline_o <= line_mem[raddr_i];
        end
    end

    // Valid bits
    always_ff @(posedge m_axi_aclk or negedge m_axi_aresetn) begin
        if (!m_axi_aresetn) begin
            valid_q <= '0;
        end else if (wen_i) begin
            valid_q[waddr_i] <= 1'b1;  // Set together with tag and line
        end
    end

    always_ff @(posedge m_axi_aclk or negedge m_axi_aresetn) begin
        if (!m_axi_aresetn) begin
            rvalid_o <= 1'b0;
        end else if (ren_i) begin
            rvalid_o <= valid_q[raddr_i];
        end
    end

endmodule

/* src/icache_pipe_reg.sv */
`timescale 1ns/1ps

module icache_pipe_reg #(
    parameter type payload_t = logic
) (
    input  logic     m_axi_aclk,
    input  logic     m_axi_aresetn,
    input  logic     flush_i,

    input  logic     up_valid_i,     // Upstream product ready
    input  logic     down_accept_i,  // Downstream accept ready
    input  logic     lock_i,
    input  logic     ready_go_i,     // Stage done with its content

    input  payload_t data_i,
    output payload_t data_o,

    output logic     valid_o,
    output logic     accept_ready_o,
    output logic     product_ready_o
);

    logic     valid_q;
    payload_t data_q;

    // Empty, or content leaves this cycle
    assign product_ready_o = valid_q && ready_go_i;
    assign accept_ready_o  = (!valid_q || (product_ready_o && down_accept_i)) && !lock_i;

    assign valid_o = valid_q;
    assign data_o  = data_q;

    always_ff @(posedge m_axi_aclk or negedge m_axi_aresetn) begin
        if (!m_axi_aresetn) begin
            valid_q <= 1'b0;
        end else if (flush_i) begin
            valid_q <= 1'b0;  // Drop whatever is in flight
        end else if (accept_ready_o) begin
            valid_q <= up_valid_i;
        end
    end

    always_ff @(posedge m_axi_aclk) begin
        if (accept_ready_o && up_valid_i) begin
            data_q <= data_i;
        end
    end

endmodule

/* src/icache_miss_ctrl.sv */
`timescale 1ns/1ps
`include "icache_config.svh"

module icache_miss_ctrl (
    input  logic               m_axi_aclk,
    input  logic               m_axi_aresetn,
    input  logic               flush_i,

    // Stage two content
    input  logic               stage_valid_i,
    input  icache_pkg::word_t  stage_pc_i,

    // Stored line for the stage two index
    input  icache_pkg::tag_t   rtag_i,
    input  logic               rvalid_i,
    input  icache_pkg::line_t  rline_i,

    output logic               ready_go_o,
    output logic               lock_o,
    output icache_pkg::word_t  inst_o,

    // Refill write into storage
    output logic               wen_o,
    output icache_pkg::index_t waddr_o,
    output icache_pkg::tag_t   wtag_o,
    output icache_pkg::line_t  wline_o,

    // AXI AR and R channels
    output logic               m_axi_arvalid_o,
    output logic               m_axi_rready_o,
    output icache_pkg::word_t  m_axi_araddr_o,
    input  logic               m_axi_arready_i,
    input  logic               m_axi_rvalid_i,
    input  icache_pkg::word_t  m_axi_rdata_i
);
    import icache_pkg::*;

    localparam int BYTE_W    = 2;
    localparam int LINE_LSB  = `ICACHE_OFFSET_W + BYTE_W;
    localparam int WORD_W    = $bits(word_t);
    localparam int LAST_BEAT = `ICACHE_LINE_WORDS - 1;

    typedef enum logic [2:0] {
        S_IDLE,
        S_ADDR,   // AR handshake
        S_DATA,   // Four R beats
        S_WRITE,  // Line into storage
        S_SYNC
    } state_t;

    state_t                      state_q;
    logic [`ICACHE_OFFSET_W-1:0] beat_q;
    line_t                       line_buf;

    tag_t                        pc_tag;
    logic [`ICACHE_OFFSET_W-1:0] pc_offset;
    logic                        hit;

    function automatic word_t pick_word(
        input line_t                       line,
        input logic [`ICACHE_OFFSET_W-1:0] sel
    );
        pick_word = line[sel*WORD_W +: WORD_W];
    endfunction

    assign pc_tag    = stage_pc_i[`ICACHE_ADDR_W-1 -: `ICACHE_TAG_W];
    assign pc_offset = stage_pc_i[BYTE_W +: `ICACHE_OFFSET_W];

    assign hit = rvalid_i && (rtag_i == pc_tag);

    // Pipeline control
    assign ready_go_o = (state_q == S_IDLE && hit) || state_q == S_SYNC;
    assign lock_o     = state_q != S_IDLE && state_q != S_SYNC;

    // Refilled word comes from the buffer, storage is one read behind
    assign inst_o = (state_q == S_SYNC) ? pick_word(line_buf, pc_offset)
                                        : pick_word(rline_i, pc_offset);

    assign m_axi_arvalid_o = state_q == S_ADDR;
    assign m_axi_rready_o  = state_q == S_DATA;
    assign m_axi_araddr_o  = {stage_pc_i[`ICACHE_ADDR_W-1:LINE_LSB], {LINE_LSB{1'b0}}};

    // Stage pc holds still while locked
    assign wen_o   = state_q == S_WRITE;
    assign waddr_o = stage_pc_i[LINE_LSB +: `ICACHE_INDEX_W];
    assign wtag_o  = pc_tag;
    assign wline_o = line_buf;

    always_ff @(posedge m_axi_aclk or negedge m_axi_aresetn) begin
        if (!m_axi_aresetn) begin
            state_q <= S_IDLE;
            beat_q  <= '0;
        end else begin
            case (state_q)
                S_IDLE: begin
                    if (stage_valid_i && !hit && !flush_i) begin
                        state_q <= S_ADDR;
                    end
                end
                S_ADDR: begin
                    if (m_axi_arready_i) begin
                        state_q <= S_DATA;
                        beat_q  <= '0;
                    end
                end
                S_DATA: begin
                    if (m_axi_rvalid_i) begin
                        beat_q <= beat_q + 1'b1;
                        if (beat_q == LAST_BEAT[`ICACHE_OFFSET_W-1:0]) begin
                            state_q <= S_WRITE;
                        end
                    end
                end
                S_WRITE: state_q <= S_SYNC;
                S_SYNC:  state_q <= S_IDLE;  // Read port catches up here
                default: state_q <= S_IDLE;
            endcase
        end
    end

    // Beats land in order, word 0 first
    always_ff @(posedge m_axi_aclk) begin
        if (state_q == S_DATA && m_axi_rvalid_i) begin
            line_buf[beat_q*WORD_W +: WORD_W] <= m_axi_rdata_i;
        end
    end

endmodule

/* src/icache_top.sv */
`timescale 1ns/1ps
`include "icache_config.svh"

module icache_top (
    input  logic              m_axi_aclk,
    input  logic              m_axi_aresetn,

    // Fetch stage side
    input  logic              if_product_ready_i,
    output logic              cache_accept_ready_o,
    input  icache_pkg::word_t if_pc_i,
    input  logic              if_branch_taken_i,
    input  logic [30:0]       if_branch_target_i,

    // Decode stage side
    input  logic              id_accept_ready_i,
    output logic              cache_product_ready_o,
    output icache_pkg::word_t cache_pc_o,
    output icache_pkg::word_t cache_inst_o,
    output logic              cache_branch_taken_o,
    output logic [30:0]       cache_branch_target_o,

    input  logic              flush_i,

    // AXI read address channel
    output logic              m_axi_arvalid_o,
    input  logic              m_axi_arready_i,
    output icache_pkg::word_t m_axi_araddr_o,
    output logic [7:0]        m_axi_arlen_o,
    output logic [1:0]        m_axi_arburst_o,
    output logic [2:0]        m_axi_arsize_o,
    output logic [0:0]        m_axi_arid_o,
    output logic [3:0]        m_axi_arcache_o,
    output logic              m_axi_arlock_o,

    // AXI read data channel
    input  logic              m_axi_rvalid_i,
    output logic              m_axi_rready_o,
    input  icache_pkg::word_t m_axi_rdata_i
);
    import icache_pkg::*;

    fetch_info_t in_info, s1_info, s2_info;
    fetch_out_t  s2_out, out_data;

    logic  s1_product, s2_product, s2_valid;
    logic  mid_accept, out_accept;
    logic  s2_ready_go, lock;
    word_t s2_inst;

    logic   rd_en, rd_valid, wr_en;
    index_t rd_index, wr_index;
    tag_t   rd_tag, wr_tag;
    line_t  rd_line, wr_line;

    assign m_axi_arlen_o   = `ICACHE_AR_LEN;
    assign m_axi_arburst_o = `ICACHE_AR_BURST;
    assign m_axi_arsize_o  = `ICACHE_AR_SIZE;
    assign m_axi_arid_o    = `ICACHE_AR_ID;
    assign m_axi_arcache_o = `ICACHE_AR_CACHE;
    assign m_axi_arlock_o  = `ICACHE_AR_LOCK;

    assign in_info = '{pc: if_pc_i, branch_taken: if_branch_taken_i,
                       branch_target: if_branch_target_i};
    assign s2_out  = '{info: s2_info, inst: s2_inst};

    // Storage read runs alongside the load into stage two
    assign rd_en    = mid_accept && s1_product;
    assign rd_index = s1_info.pc[`ICACHE_OFFSET_W+2 +: `ICACHE_INDEX_W];

    icache_store u_store (
        .m_axi_aclk    (m_axi_aclk),
        .m_axi_aresetn (m_axi_aresetn),
        .ren_i         (rd_en),
        .raddr_i       (rd_index),
        .wen_i         (wr_en),
        .waddr_i       (wr_index),
        .wtag_i        (wr_tag),
        .wline_i       (wr_line),
        .rtag_o        (rd_tag),
        .rvalid_o      (rd_valid),
        .rline_o       (rd_line)
    );

    icache_pipe_reg #(.payload_t(fetch_info_t)) u_in_reg (
        .m_axi_aclk      (m_axi_aclk),
        .m_axi_aresetn   (m_axi_aresetn),
        .flush_i         (flush_i),
        .up_valid_i      (if_product_ready_i),
        .down_accept_i   (mid_accept),
        .lock_i          (1'b0),
        .ready_go_i      (1'b1),  // Stage one only reads storage
        .data_i          (in_info),
        .data_o          (s1_info),
        .valid_o         (),
        .accept_ready_o  (cache_accept_ready_o),
        .product_ready_o (s1_product)
    );

    icache_pipe_reg #(.payload_t(fetch_info_t)) u_mid_reg (
        .m_axi_aclk      (m_axi_aclk),
        .m_axi_aresetn   (m_axi_aresetn),
        .flush_i         (flush_i),
        .up_valid_i      (s1_product),
        .down_accept_i   (out_accept),
        .lock_i          (lock),        // Held during refill
        .ready_go_i      (s2_ready_go),
        .data_i          (s1_info),
        .data_o          (s2_info),
        .valid_o         (s2_valid),
        .accept_ready_o  (mid_accept),
        .product_ready_o (s2_product)
    );

    icache_pipe_reg #(.payload_t(fetch_out_t)) u_out_reg (
        .m_axi_aclk      (m_axi_aclk),
        .m_axi_aresetn   (m_axi_aresetn),
        .flush_i         (flush_i),
        .up_valid_i      (s2_product),
        .down_accept_i   (id_accept_ready_i),
        .lock_i          (1'b0),
        .ready_go_i      (1'b1),
        .data_i          (s2_out),
        .data_o          (out_data),
        .valid_o         (),
        .accept_ready_o  (out_accept),
        .product_ready_o (cache_product_ready_o)
    );

    icache_miss_ctrl u_miss_ctrl (
        .m_axi_aclk      (m_axi_aclk),
        .m_axi_aresetn   (m_axi_aresetn),
        .flush_i         (flush_i),
        .stage_valid_i   (s2_valid),
        .stage_pc_i      (s2_info.pc),
        .rtag_i          (rd_tag),
        .rvalid_i        (rd_valid),
        .rline_i         (rd_line),
        .ready_go_o      (s2_ready_go),
        .lock_o          (lock),
        .inst_o          (s2_inst),
        .wen_o           (wr_en),
        .waddr_o         (wr_index),
        .wtag_o          (wr_tag),
        .wline_o         (wr_line),
        .m_axi_arvalid_o (m_axi_arvalid_o),
        .m_axi_rready_o  (m_axi_rready_o),
        .m_axi_araddr_o  (m_axi_araddr_o),
        .m_axi_arready_i (m_axi_arready_i),
        .m_axi_rvalid_i  (m_axi_rvalid_i),
        .m_axi_rdata_i   (m_axi_rdata_i)
    );

    assign cache_pc_o            = out_data.info.pc;
    assign cache_inst_o          = out_data.inst;
    assign cache_branch_taken_o  = out_data.info.branch_taken;
    assign cache_branch_target_o = out_data.info.branch_target;

endmodule

/* verification/axi_rd_mem_model.sv */
`timescale 1ns/1ps

module axi_rd_mem_model #(
    parameter logic [31:0] SEED = 32'h730bf0a5
) (
    input  logic        m_axi_aclk,
    input  logic        m_axi_aresetn,
    input  logic        arvalid_i,
    input  logic [31:0] araddr_i,
    input  logic [7:0]  arlen_i,
    output logic        arready_o,
    output logic        rvalid_o,
    input  logic        rready_i,
    output logic [31:0] rdata_o
);

    logic [31:0] lcg_state;
    logic [31:0] beat_addr;
    logic [2:0]  beats_left;
    logic        busy;
    logic        took;

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        lcg_next = s * 32'd1664525 + 32'd1013904223;
    endfunction

    initial begin
        arready_o  = 1'b0;
        rvalid_o   = 1'b0;
        rdata_o    = '0;
        busy       = 1'b0;
        took       = 1'b0;
        beat_addr  = '0;
        beats_left = '0;
        lcg_state  = SEED;
        forever begin
            @(posedge m_axi_aclk);
            took = rvalid_o && rready_i;
            if (!m_axi_aresetn) begin
                busy = 1'b0;
            end else if (arvalid_i && arready_o) begin
                busy       = 1'b1;  // Burst accepted
                beat_addr  = araddr_i;
                beats_left = arlen_i[2:0] + 3'd1;
            end else if (took) begin
                beat_addr  = beat_addr + 32'd4;
                beats_left = beats_left - 3'd1;
                busy       = beats_left != 3'd0;
            end
            #1;
            lcg_state = lcg_next(lcg_state);
            arready_o = m_axi_aresetn && !busy && arvalid_i && lcg_state[17:16] != 2'b00;
            // An unconsumed beat stays on the bus
            if (!(rvalid_o && !took)) begin
                rvalid_o = m_axi_aresetn && busy && lcg_state[19:18] != 2'b00;
            end
            rdata_o = ~beat_addr ^ 32'h5a5a0000;  // Word derived from its address
        end
    end

endmodule

/* verification/tb_icache.sv */
`timescale 1ns/1ps

module tb_icache;
    localparam logic [31:0] SEED = 32'h730bf0a5;
    localparam int WAIT_LIMIT = 4000;

    logic        m_axi_aclk, m_axi_aresetn, flush;
    logic        if_valid, if_taken, id_ready, deliver;
    logic [31:0] if_pc;
    logic [30:0] if_target;
    logic        cache_accept, cache_product, cache_taken;
    logic [31:0] cache_pc, cache_inst;
    logic [30:0] cache_target;
    logic        arvalid, arready, rvalid, rready, arlock;
    logic [31:0] araddr, rdata;
    logic [7:0]  arlen;
    logic [1:0]  arburst;
    logic [2:0]  arsize;
    logic [0:0]  arid;
    logic [3:0]  arcache;

    logic [63:0] sb_q[$];  // {pc, taken, target} per accepted fetch
    logic [95:0] exp_fetch, prev_out, cur_out;
    logic [2:0]  hit_pipe;
    logic        hit_phase, ar_chk, stall_prev;
    logic [31:0] stim_rand, dec_rand;
    logic [31:0] pc_pool [8];
    int          sb_count, error_count, timeout_count, ar_count, exp_ars, reset_age;
    int          decode_mode, delivered;
    string       test_name;

    assign deliver = cache_product && id_ready;
    assign cur_out = {cache_pc, cache_taken, cache_target, cache_inst};

    icache_top uut (
        .m_axi_aclk(m_axi_aclk), .m_axi_aresetn(m_axi_aresetn),
        .if_product_ready_i(if_valid), .cache_accept_ready_o(cache_accept),
        .if_pc_i(if_pc), .if_branch_taken_i(if_taken), .if_branch_target_i(if_target),
        .id_accept_ready_i(id_ready), .cache_product_ready_o(cache_product),
        .cache_pc_o(cache_pc), .cache_inst_o(cache_inst),
        .cache_branch_taken_o(cache_taken), .cache_branch_target_o(cache_target),
        .flush_i(flush),
        .m_axi_arvalid_o(arvalid), .m_axi_arready_i(arready), .m_axi_araddr_o(araddr),
        .m_axi_arlen_o(arlen), .m_axi_arburst_o(arburst), .m_axi_arsize_o(arsize),
        .m_axi_arid_o(arid), .m_axi_arcache_o(arcache), .m_axi_arlock_o(arlock),
        .m_axi_rvalid_i(rvalid), .m_axi_rready_o(rready), .m_axi_rdata_i(rdata)
    );

    axi_rd_mem_model #(.SEED(SEED)) u_mem (
        .m_axi_aclk(m_axi_aclk), .m_axi_aresetn(m_axi_aresetn),
        .arvalid_i(arvalid), .araddr_i(araddr), .arlen_i(arlen), .arready_o(arready),
        .rvalid_o(rvalid), .rready_i(rready), .rdata_o(rdata)
    );

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        lcg_next = s * 32'd1664525 + 32'd1013904223;
    endfunction

    initial begin
        m_axi_aclk = 1'b0;
        forever #20 m_axi_aclk = ~m_axi_aclk;
    end

    // Decode ready is low in mode 0, high in mode 1 and random in mode 2
    initial begin
        id_ready = 1'b0;
        dec_rand = SEED;
        forever begin
            @(posedge m_axi_aclk);
            #1;
            dec_rand = lcg_next(dec_rand);
            id_ready = (decode_mode == 2) ? dec_rand[20] : (decode_mode == 1);
        end
    end

    // Scoreboard and bookkeeping sampled at the rising edge
    always @(posedge m_axi_aclk) begin
        if (!m_axi_aresetn) begin
            sb_q.delete();
            ar_count  = 0;
            delivered = 0;
            reset_age = 0;
        end else begin
            if (reset_age < 100) reset_age++;
            if (flush) begin
                sb_q.delete();  // Everything in flight is dropped
            end else begin
                if (deliver && sb_q.size() != 0) begin
                    void'(sb_q.pop_front());
                    delivered++;
                end
                if (if_valid && cache_accept) sb_q.push_back({if_pc, if_taken, if_target});
            end
            if (arvalid && arready) ar_count++;
        end
        hit_pipe   <= {hit_pipe[1:0], hit_phase && if_valid && cache_accept};
        stall_prev <= m_axi_aresetn && cache_product && !id_ready && !flush;
        prev_out   <= cur_out;
        sb_count = sb_q.size();
        if (sb_count != 0) exp_fetch = {sb_q[0], ~sb_q[0][63:32] ^ 32'h5a5a0000};
    end

    assert property (@(negedge m_axi_aclk)
        reset_age > 1 || (!arvalid && !rready && !cache_product))
    else begin
        error_count++;
        $display("%s: AXI or output valid high out of reset", test_name);
    end

    assert property (@(negedge m_axi_aclk) disable iff (!m_axi_aresetn)
        !deliver || (sb_count != 0 && cur_out == exp_fetch))
    else begin
        error_count++;
        $display("error %s: fetch expected %h actual %h", test_name, exp_fetch, cur_out);
    end

    assert property (@(negedge m_axi_aclk) disable iff (!m_axi_aresetn)
        !arvalid || {araddr[3:0], arlen, arburst, arsize, arid, arcache, arlock} ==
                    {4'h0, 8'd3, 2'b01, 3'b010, 1'b0, 4'hf, 1'b0})
    else begin
        error_count++;
        $display("error %s: ar expected %h actual %h", test_name, {4'h0, 8'd3, 2'b01, 3'b010,
                 1'b0, 4'hf, 1'b0}, {araddr[3:0], arlen, arburst, arsize, arid, arcache, arlock});
    end

    assert property (@(negedge m_axi_aclk) disable iff (!m_axi_aresetn)
        !ar_chk || ar_count == exp_ars)
    else begin
        error_count++;
        $display("error %s: ar count expected %0d actual %0d", test_name, exp_ars, ar_count);
    end

    assert property (@(negedge m_axi_aclk) disable iff (!m_axi_aresetn)
        (!hit_pipe[2] || cache_product) && !(hit_phase && arvalid))
    else begin
        error_count++;
        $display("%s: hit fetch late or refilled", test_name);
    end

    assert property (@(negedge m_axi_aclk) disable iff (!m_axi_aresetn)
        !stall_prev || (cache_product && cur_out == prev_out))
    else begin
        error_count++;
        $display("error %s: held output expected %h actual %h", test_name, prev_out, cur_out);
    end

    task automatic send_fetch(input logic [31:0] pc, input logic taken, input logic [30:0] tgt);
        int   waited;
        logic took;
        if_valid  = 1'b1;
        if_pc     = pc;
        if_taken  = taken;
        if_target = tgt;
        waited    = 0;
        took      = 1'b0;
        while (!took && waited < WAIT_LIMIT) begin
            @(negedge m_axi_aclk);
            took = cache_accept;
            @(posedge m_axi_aclk);
            #1;
            waited++;
        end
        if (!took) begin
            timeout_count++;
            $display("%s: fetch at pc %h was never accepted", test_name, pc);
        end
        if_valid = 1'b0;
    endtask

    task automatic drain_pipeline();
        int waited;
        decode_mode = 1;
        waited      = 0;
        while (sb_count != 0 && waited < WAIT_LIMIT) begin
            @(posedge m_axi_aclk);
            #1;
            waited++;
        end
        if (sb_count != 0) begin
            timeout_count++;
            $display("%s: pending fetches were never delivered", test_name);
        end
        repeat (4) @(posedge m_axi_aclk);
        #1;
    endtask

    task automatic report_and_finish();
        $display("errors %0d, timeouts %0d, delivered %0d", error_count, timeout_count, delivered);
        if (error_count == 0 && timeout_count == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    endtask

    initial begin
        m_axi_aresetn = 1'b0;
        flush         = 1'b0;
        if_valid      = 1'b0;
        if_pc         = '0;
        if_taken      = 1'b0;
        if_target     = '0;
        hit_phase     = 1'b0;
        ar_chk        = 1'b0;
        exp_ars       = 0;
        error_count   = 0;
        timeout_count = 0;
        decode_mode   = 1;
        test_name     = "reset";
        stim_rand     = lcg_next(SEED);
        pc_pool = '{32'h1000, 32'h1004, 32'h1040, 32'h41040, 32'h300c, 32'h2008,
                    32'h41044, 32'h1048};  // 0x1040 and 0x41040 share an index
        repeat (16) @(posedge m_axi_aclk);
        #1;
        m_axi_aresetn = 1'b1;

        test_name = "miss_line";
        exp_ars   = ar_count + 1;
        for (int i = 0; i < 4; i++) send_fetch(32'h1000 + 32'(i * 4), i[0], 31'(i));
        drain_pipeline();
        ar_chk = 1'b1;
        @(posedge m_axi_aclk);
        #1;
        ar_chk = 1'b0;

        test_name = "warm";
        send_fetch(32'h2020, 1'b1, 31'h100);  // Index 2, line 0x1000 stays resident
        drain_pipeline();

        test_name = "hit_stream";
        hit_phase = 1'b1;
        for (int i = 0; i < 12; i++) begin
            send_fetch((i[0] ? 32'h2020 : 32'h1000) + 32'((i / 2) % 4 * 4), 1'b0, 31'(i));
        end
        drain_pipeline();
        hit_phase = 1'b0;

        test_name   = "stall";
        decode_mode = 2;
        for (int i = 0; i < 40; i++) begin
            stim_rand = lcg_next(stim_rand);
            send_fetch(pc_pool[stim_rand[10:8]], stim_rand[3], stim_rand[30:0]);
        end
        drain_pipeline();

        test_name   = "flush";
        decode_mode = 0;
        send_fetch(32'h5000, 1'b1, 31'h5);
        send_fetch(32'h6000, 1'b0, 31'h6);
        repeat (3) @(posedge m_axi_aclk);
        #1;
        flush = 1'b1;  // Refill of 0x5000 still running
        @(posedge m_axi_aclk);
        #1;
        flush       = 1'b0;
        decode_mode = 1;
        send_fetch(32'h7000, 1'b0, 31'h7);
        send_fetch(32'h5000, 1'b1, 31'h15);
        send_fetch(32'h5008, 1'b0, 31'h18);
        send_fetch(32'h6004, 1'b1, 31'h24);
        drain_pipeline();

        report_and_finish();
    end

endmodule

/* src.f */
+incdir+src
src/icache_pkg.sv
src/icache_store.sv
src/icache_pipe_reg.sv
src/icache_miss_ctrl.sv
src/icache_top.sv
verification/axi_rd_mem_model.sv
verification/tb_icache.sv

/* run_sim.sh */
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --top-module tb_icache -f src.f -o sim_icache || exit 1
out=$(./obj_dir/sim_icache)
echo "$out"
echo "$out" | grep -qx "test passed" && exit 0 || exit 1
